// File: floor_logic_control_unit.f
rtl/floor_pkg.sv
rtl/request_if.sv
rtl/request_bank.sv
rtl/car_control.sv
rtl/floor_logic_control_unit.sv
tests/floor_logic_properties.sv
tests/floor_logic_tb.sv

// File: rtl/car_control.sv
`timescale 1ns/1ps

module car_control import floor_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  floor_t     current_floor,
    input  logic       elevator_moving,
    input  logic       power_switch,
    input  logic       emergency_btn,
    input  logic       door_open_btn,
    input  logic       door_close_btn,
    request_if.control req,
    output floor_t     elevator_floor_selector,
    output logic       direction_selector,
    output logic       activate_elevator,
    output logic       door_open_allowed,
    output logic       door_close_allowed
);

    dispatch_state_t state;

    floor_mask_t pending;
    logic        here_lit;
    logic        up_found;
    floor_t      up_floor;
    logic        down_found;
    floor_t      down_floor;
    logic        next_found;
    floor_t      next_target;
    logic        next_dir;
    logic        car_ok;
    logic        at_target;

    //////////////////////////////
    // Sweep target search
    //////////////////////////////

    // Hall calls and car calls are served alike
    assign pending  = req.call_lights | req.panel_lights;
    assign here_lit = |(pending & (floor_mask_t'(1) << current_floor));

    // Lowest lit floor above the car, scanning top down so the last hit wins
    always_comb begin
        up_found = 1'b0;
        up_floor = '0;
        for (int i = num_floors - 1; i >= 0; i--) begin
            if (pending[i] && (floor_t'(i) > current_floor)) begin
                up_found = 1'b1;
                up_floor = floor_t'(i);
            end
        end
    end

    // Highest lit floor below the car
    always_comb begin
        down_found = 1'b0;
        down_floor = '0;
        for (int i = 0; i < num_floors; i++) begin
            if (pending[i] && (floor_t'(i) < current_floor)) begin
                down_found = 1'b1;
                down_floor = floor_t'(i);
            end
        end
    end

    // Keep sweeping while there is work ahead, otherwise turn around.
    // A lamp left lit at the car's own floor (after an aborted trip) is
    // taken last so it still gets cleared
    always_comb begin
        next_found  = 1'b1;
        next_target = current_floor;
        next_dir    = direction_selector;
        if (direction_selector == dir_up) begin
            if (up_found) begin
                next_target = up_floor;
            end else if (down_found) begin
                next_target = down_floor;
                next_dir    = dir_down;
            end else if (!here_lit) begin
                next_found = 1'b0;
            end
        end else begin
            if (down_found) begin
                next_target = down_floor;
            end else if (up_found) begin
                next_target = up_floor;
                next_dir    = dir_up;
            end else if (!here_lit) begin
                next_found = 1'b0;
            end
        end
    end

    //////////////////////////////
    // Dispatch FSM
    //////////////////////////////

    assign car_ok    = power_switch && !emergency_btn;
    assign at_target = !elevator_moving && (current_floor == elevator_floor_selector);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state                   <= dispatch_idle;
            elevator_floor_selector <= '0;
            direction_selector      <= dir_up;
            activate_elevator       <= 1'b0;
        end else begin
            case (state)
                dispatch_idle: begin
                    if (next_found && !elevator_moving && car_ok) begin
                        elevator_floor_selector <= next_target;
                        direction_selector      <= next_dir;
                        activate_elevator       <= 1'b1;
                        state                   <= dispatch_run;
                    end
                end
                dispatch_run: begin
                    // Abort keeps the lamps, the trip is picked up again later
                    if (!car_ok) begin
                        activate_elevator <= 1'b0;
                        state             <= dispatch_idle;
                    end else if (at_target) begin
                        activate_elevator <= 1'b0;
                        state             <= dispatch_arrive;
                    end
                end
                dispatch_arrive: begin
                    state <= dispatch_idle;
                end
                default: begin
                    activate_elevator <= 1'b0;
                    state             <= dispatch_idle;
                end
            endcase
        end
    end

    // Lamps drop at the edge that leaves dispatch_arrive
    assign req.arrive_clear = (state == dispatch_arrive);
    assign req.arrive_floor = elevator_floor_selector;

    //////////////////////////////
    // Door permissions
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= !elevator_moving && power_switch && door_open_btn;
            door_close_allowed <= !elevator_moving && power_switch && door_close_btn;
        end
    end

endmodule

// File: rtl/floor_logic_control_unit.sv
`timescale 1ns/1ps

module floor_logic_control_unit import floor_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,

    // Buttons
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        door_open_btn,
    input  logic        door_close_btn,
    input  logic        emergency_btn,
    input  logic        power_switch,

    // Car status
    input  floor_t      current_floor,
    input  logic        elevator_moving,

    // Commands to the car
    output floor_t      elevator_floor_selector,
    output logic        direction_selector,
    output logic        activate_elevator,
    output logic        door_open_allowed,
    output logic        door_close_allowed,

    // Lamps
    output floor_mask_t call_button_lights,
    output floor_mask_t panel_button_lights
);

    request_if req_bus ();

    //////////////////////////////
    // Request lamps
    //////////////////////////////

    request_bank u_request_bank (
        .clock              (clock),
        .reset_n            (reset_n),
        .floor_call_buttons (floor_call_buttons),
        .panel_buttons      (panel_buttons),
        .current_floor      (current_floor),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .req                (req_bus.bank)
    );

    //////////////////////////////
    // Dispatch and doors
    //////////////////////////////

    car_control u_car_control (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .req                     (req_bus.control),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

    // Lamp state leaves the chip straight from the bank registers
    assign call_button_lights  = req_bus.call_lights;
    assign panel_button_lights = req_bus.panel_lights;

endmodule

// File: rtl/floor_pkg.sv
package floor_pkg;

    //////////////////////////////
    // Building geometry
    //////////////////////////////

    // Serviced floors, floor 1 is index 0
    localparam int num_floors  = 11;
    localparam int floor_width = 4;

    // Sweep direction encoding, as seen on direction_selector
    localparam logic dir_up   = 1'b1;
    localparam logic dir_down = 1'b0;

    //////////////////////////////
    // Types
    //////////////////////////////

    // Floor index, 0 for floor 1 through 10 for floor 11
    typedef logic [floor_width-1:0] floor_t;

    // One bit per floor, for buttons and lamps
    typedef logic [num_floors-1:0] floor_mask_t;

    // Dispatch FSM
    // idle   : waiting for a lit lamp and a stopped, powered car
    // run    : activate_elevator high until the car reports arrival
    // arrive : one cycle to clear the lamps of the reached floor
    typedef enum logic [1:0] {
        dispatch_idle   = 2'd0,
        dispatch_run    = 2'd1,
        dispatch_arrive = 2'd2
    } dispatch_state_t;

endpackage

// File: rtl/request_bank.sv
`timescale 1ns/1ps

module request_bank import floor_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  floor_t      current_floor,
    input  logic        power_switch,
    input  logic        emergency_btn,
    request_if.bank     req
);

    floor_mask_t here_mask;
    floor_mask_t clear_mask;
    floor_mask_t press_enable;
    floor_mask_t call_next;
    floor_mask_t panel_next;
    floor_mask_t call_lamps;
    floor_mask_t panel_lamps;

    //////////////////////////////
    // Press qualification
    //////////////////////////////

    // The floor the car sits at never lights, it is served already
    assign here_mask = floor_mask_t'(1) << current_floor;

    // All buttons are dead with power off or in an emergency
    assign press_enable = (power_switch && !emergency_btn) ? ~here_mask : '0;

    // Arrival wipes hall and car lamps of the reached floor together
    assign clear_mask = req.arrive_clear ? (floor_mask_t'(1) << req.arrive_floor) : '0;

    // Every pressed button lands in the same cycle, clear wins on overlap
    assign call_next  = (call_lamps  | (floor_call_buttons & press_enable)) & ~clear_mask;
    assign panel_next = (panel_lamps | (panel_buttons      & press_enable)) & ~clear_mask;

    //////////////////////////////
    // Lamp registers
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lamps  <= '0;
            panel_lamps <= '0;
        end else begin
            call_lamps  <= call_next;
            panel_lamps <= panel_next;
        end
    end

    assign req.call_lights  = call_lamps;
    assign req.panel_lights = panel_lamps;

endmodule

// File: rtl/request_if.sv
`timescale 1ns/1ps

interface request_if import floor_pkg::*; ();

    // Lamp state, owned by the request bank
    floor_mask_t panel_lights;
    floor_mask_t call_lights;

    // Single cycle clear of both lamps at arrive_floor
    logic        arrive_clear;
    floor_t      arrive_floor;

    // Request bank side
    modport bank (
        output panel_lights,
        output call_lights,
        input  arrive_clear,
        input  arrive_floor
    );

    // Dispatch side
    modport control (
        input  panel_lights,
        input  call_lights,
        output arrive_clear,
        output arrive_floor
    );

endinterface

// File: tests/floor_logic_properties.sv
`timescale 1ns/1ps

module floor_logic_properties import floor_pkg::*; (
    input logic            clock,
    input logic            reset_n,
    input dispatch_state_t state,
    input logic            activate_elevator,
    input logic            arrive_clear,
    input logic            elevator_moving,
    input logic            door_open_allowed,
    input logic            door_close_allowed
);

    //////////////////////////////
    // Dispatch FSM
    //////////////////////////////

    // The car is only told to move while a trip is open
    activate_only_in_run: assert property (
        @(posedge clock) disable iff (!reset_n)
        activate_elevator |-> (state == dispatch_run)
    ) else $error("activate_elevator high outside dispatch_run");

    // Lamp clear is a single pulse per arrival
    arrive_clear_single: assert property (
        @(posedge clock) disable iff (!reset_n)
        arrive_clear |=> !arrive_clear
    ) else $error("arrive_clear held for more than one cycle");

    //////////////////////////////
    // Doors
    //////////////////////////////

    // Door permissions are registered, so they lag the moving flag by one cycle
    doors_closed_when_moving: assert property (
        @(posedge clock) disable iff (!reset_n)
        $past(elevator_moving) |-> (!door_open_allowed && !door_close_allowed)
    ) else $error("door permission granted while the car was moving");

endmodule

bind car_control floor_logic_properties u_properties (
    .clock              (clock),
    .reset_n            (reset_n),
    .state              (state),
    .activate_elevator  (activate_elevator),
    .arrive_clear       (req.arrive_clear),
    .elevator_moving    (elevator_moving),
    .door_open_allowed  (door_open_allowed),
    .door_close_allowed (door_close_allowed)
);

// File: tests/floor_logic_tb.sv
`timescale 1ns/1ps

module floor_logic_tb import floor_pkg::*; ();

    localparam int num_cols   = 8;
    localparam int max_steps  = 64;
    localparam int wait_limit = 40;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor;
    logic        elevator_moving;
    floor_t      elevator_floor_selector;
    logic        direction_selector;
    logic        activate_elevator;
    logic        door_open_allowed;
    logic        door_close_allowed;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;

    logic [15:0] vectors [0:max_steps*num_cols-1];
    int          error_count;
    int          timeout_count;
    int          step;
    int          base;
    bit          run_done;

    floor_logic_control_unit dut_i (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .floor_call_buttons      (floor_call_buttons),
        .panel_buttons           (panel_buttons),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights)
    );

    always #20 clock = ~clock;

    //////////////////////////////
    // Step tasks
    //////////////////////////////

    task automatic compare_value(input logic [15:0] actual, input logic [15:0] expected,
                                 input string what);
        if (actual !== expected) begin
            $display("FAILED at %t: %s is %0h, expected %0h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) @(negedge clock);
    endtask

    // Buttons are held for one clock, then released
    task automatic press_buttons(input logic [15:0] calls, input logic [15:0] panels);
        floor_call_buttons = floor_mask_t'(calls);
        panel_buttons      = floor_mask_t'(panels);
        @(negedge clock);
        floor_call_buttons = '0;
        panel_buttons      = '0;
    endtask

    // Plays the car motion FSM and the switch panel
    task automatic set_car(input int base_index);
        current_floor   = floor_t'(vectors[base_index+1]);
        elevator_moving = vectors[base_index+2][0];
        power_switch    = vectors[base_index+3][0];
        emergency_btn   = vectors[base_index+4][0];
        door_open_btn   = vectors[base_index+5][0];
        door_close_btn  = vectors[base_index+6][0];
        @(negedge clock);
    endtask

    task automatic wait_activate(input logic level);
        int cycles;
        cycles = 0;
        while (activate_elevator !== level && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (activate_elevator !== level) begin
            $display("Timeout: activate_elevator did not reach %0b within %0d cycles",
                     level, wait_limit);
            timeout_count++;
            run_done = 1'b1;
        end
    endtask

    task automatic check_outputs(input int base_index);
        compare_value(call_button_lights, vectors[base_index+1], "call_button_lights");
        compare_value(panel_button_lights, vectors[base_index+2], "panel_button_lights");
        compare_value(elevator_floor_selector, vectors[base_index+3], "elevator_floor_selector");
        compare_value(direction_selector, vectors[base_index+4], "direction_selector");
        compare_value(activate_elevator, vectors[base_index+5], "activate_elevator");
        compare_value(door_open_allowed, vectors[base_index+6], "door_open_allowed");
        compare_value(door_close_allowed, vectors[base_index+7], "door_close_allowed");
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(50545));
        clock              = 1'b0;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        current_floor      = '0;
        elevator_moving    = 1'b0;
        error_count        = 0;
        timeout_count      = 0;
        run_done           = 1'b0;
        step               = 0;

        $readmemh("tests/floor_logic_vectors.txt", vectors);
        if ($isunknown(vectors[0])) begin
            $display("The vector file could not be read");
            error_count++;
        end

        repeat (2) @(negedge clock);
        reset_n = 1'b1;

        while (!run_done && step < max_steps) begin
            base = step * num_cols;
            case (vectors[base])
                16'h1: begin
                    idle_cycles($urandom % 3);
                    press_buttons(vectors[base+1], vectors[base+2]);
                end
                16'h2: begin
                    idle_cycles($urandom % 3);
                    set_car(base);
                end
                16'h3: wait_activate(vectors[base+1][0]);
                16'h4: check_outputs(base);
                16'h5: idle_cycles(int'(vectors[base+1]));
                default: run_done = 1'b1;
            endcase
            step++;
        end

        $display("Summary: %0d mismatches, %0d timeouts over %0d steps",
                 error_count, timeout_count, step);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: tests/floor_logic_vectors.txt
// act a b c d e f g, all hex, one step per line
// act 1 press: a hall call buttons, b car panel buttons, held for one cycle
// act 2 car: a floor, b moving, c power, d emergency, e door open btn, f door close btn
// act 3 wait: a level of activate_elevator, act 5 idle: a cycles, act 0 ends the run
// act 4 check: a call lamps, b panel lamps, c selector, d direction, e activate,
//              f door open allowed, g door close allowed
4 000 000 0 1 0 0 0
2 5 0 0 0 0 0 0
1 008 000 0 0 0 0 0
4 000 000 0 1 0 0 0
2 5 0 1 1 0 0 0
1 008 000 0 0 0 0 0
4 000 000 0 1 0 0 0
2 5 1 1 0 0 0 0
1 020 020 0 0 0 0 0
4 000 000 0 1 0 0 0
1 008 100 0 0 0 0 0
4 008 100 0 1 0 0 0
2 5 1 1 0 1 1 0
4 008 100 0 1 0 0 0
2 5 0 1 0 0 0 0
3 1 0 0 0 0 0 0
4 008 100 8 1 1 0 0
2 5 0 1 0 1 0 0
4 008 100 8 1 1 1 0
2 6 1 1 0 0 0 0
4 008 100 8 1 1 0 0
2 8 1 1 0 0 0 0
4 008 100 8 1 1 0 0
2 8 0 1 0 0 0 0
3 0 0 0 0 0 0 0
3 1 0 0 0 0 0 0
4 008 000 3 0 1 0 0
2 8 0 1 1 0 0 0
4 008 000 3 0 0 0 0
2 8 0 0 0 1 1 0
4 008 000 3 0 0 0 0
2 8 0 1 0 0 1 0
4 008 000 3 0 1 0 1
2 5 1 1 0 0 0 0
2 3 1 1 0 0 0 0
2 3 0 1 0 0 0 0
3 0 0 0 0 0 0 0
5 2 0 0 0 0 0 0
4 000 000 3 0 0 0 0
1 000 400 0 0 0 0 0
3 1 0 0 0 0 0 0
4 000 400 a 1 1 0 0
2 a 1 1 0 0 0 0
2 a 0 1 0 0 0 0
3 0 0 0 0 0 0 0
5 2 0 0 0 0 0 0
4 000 000 a 1 0 0 0
0 0 0 0 0 0 0 0
